/* design/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Operand and address width
`define XLEN 32

// Architectural integer registers
`define REG_COUNT 32

// Data memory size in 32-bit words
`define DMEM_WORDS 64

`endif

/* design/rv_isa_pkg.sv */
`default_nettype none

`include "core_macros.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_sel_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    // funct3 of the integer ALU instructions
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SR      = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    // Only whole-word loads and stores
    localparam logic [2:0] F3_WORD = 3'b010;

    // ADD first so that a cleared bundle adds
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

endpackage

`default_nettype wire

/* design/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    import rv_isa_pkg::*;

    // All zero is a bubble
    typedef struct packed {
        logic    mem_write;
        logic    mem_read;
        logic    mem_to_reg;
        logic    reg_wr_en;
        logic    alu_src;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t instruction;
    } if_id_t;

    typedef struct packed {
        word_t    rs_data1;
        word_t    rs_data2;
        word_t    imm;
        reg_sel_t rd_sel;
        ctrl_t    ctrl;
    } id_ex_t;

    // rs_data2 is the store data from here on
    typedef struct packed {
        word_t    alu_result;
        word_t    rs_data2;
        reg_sel_t rd_sel;
        ctrl_t    ctrl;
    } ex_mem_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    mem_data;
        reg_sel_t rd_sel;
        ctrl_t    ctrl;
    } mem_wb_t;

endpackage

`default_nettype wire

/* design/pipe_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module if_id import pipe_pkg::*; (
    input  wire    clk,
    input  wire    rst,
    input  wire    if_id_t i_d,
    output if_id_t o_q
);

    // Zero instruction decodes as a bubble
    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            o_q <= '0;
        end
        else
        begin
            o_q <= i_d;
        end
    end

endmodule

module id_ex import pipe_pkg::*; (
    input  wire    clk,
    input  wire    rst,
    input  wire    id_ex_t i_d,
    output id_ex_t o_q
);

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            o_q <= '0;
        end
        else
        begin
            o_q <= i_d;
        end
    end

endmodule

module ex_mem import pipe_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    input  wire     ex_mem_t i_d,
    output ex_mem_t o_q
);

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            o_q <= '0;
        end
        else
        begin
            o_q <= i_d;
        end
    end

endmodule

module mem_wb import pipe_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    input  wire     mem_wb_t i_d,
    output mem_wb_t o_q
);

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            o_q <= '0;
        end
        else
        begin
            o_q <= i_d;
        end
    end

endmodule

`default_nettype wire

/* design/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder import rv_isa_pkg::*, pipe_pkg::*; (
    input  wire      word_t i_instruction,
    output reg_sel_t o_rs1_sel,
    output reg_sel_t o_rs2_sel,
    output reg_sel_t o_rd_sel,
    output word_t    o_imm,
    output ctrl_t    o_ctrl
);

    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_u;
    funct3_e funct3;
    logic    alt;

    assign imm_i  = {{20{i_instruction[31]}}, i_instruction[31:20]};
    assign imm_s  = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};
    assign imm_u  = {i_instruction[31:12], 12'b0};
    assign funct3 = funct3_e'(i_instruction[14:12]);
    // funct7 bit 5 selects SUB and SRA
    assign alt    = i_instruction[30];

    function automatic alu_op_e alu_sel(input funct3_e f3, input logic sub_ok, input logic sra);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = sub_ok ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SR:      op = sra ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb
    begin
        o_rs1_sel = i_instruction[19:15];
        o_rs2_sel = i_instruction[24:20];
        o_rd_sel  = i_instruction[11:7];
        o_imm     = '0;
        o_ctrl    = '0;

        case (opcode_e'(i_instruction[6:0]))
            OP:
            begin
                o_ctrl.reg_wr_en = 1'b1;
                o_ctrl.alu_op    = alu_sel(funct3, alt, alt);
            end
            OP_IMM:
            begin
                o_imm            = imm_i;
                o_ctrl.reg_wr_en = 1'b1;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.alu_op    = alu_sel(funct3, 1'b0, alt);
            end
            LUI:
            begin
                // Immediate added to x0
                o_rs1_sel        = '0;
                o_imm            = imm_u;
                o_ctrl.reg_wr_en = 1'b1;
                o_ctrl.alu_src   = 1'b1;
            end
            LOAD:
            begin
                if (funct3 == F3_WORD)
                begin
                    o_imm             = imm_i;
                    o_ctrl.reg_wr_en  = 1'b1;
                    o_ctrl.mem_read   = 1'b1;
                    o_ctrl.mem_to_reg = 1'b1;
                    o_ctrl.alu_src    = 1'b1;
                end
            end
            STORE:
            begin
                if (funct3 == F3_WORD)
                begin
                    o_imm            = imm_s;
                    o_ctrl.mem_write = 1'b1;
                    o_ctrl.alu_src   = 1'b1;
                end
            end
            default:
            begin
                o_ctrl = '0;
            end
        endcase

        // Results aimed at x0 are dropped here
        if (o_rd_sel == '0)
        begin
            o_ctrl.reg_wr_en = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module reg_file import rv_isa_pkg::*; (
    input  wire      clk,
    input  wire      rst,
    input  wire      reg_sel_t i_rs1_sel,
    input  wire      reg_sel_t i_rs2_sel,
    input  wire      i_wr_en,
    input  wire      reg_sel_t i_rd_sel,
    input  wire      word_t i_wr_data,
    output word_t    o_rs1_data,
    output word_t    o_rs2_data
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wr_en && (i_rd_sel != '0))
        begin
            regs[i_rd_sel] <= i_wr_data;
        end
    end

    // Write-through covers the writeback cycle
    always_comb
    begin
        if (i_rs1_sel == '0)
            o_rs1_data = '0;
        else if (i_wr_en && (i_rs1_sel == i_rd_sel))
            o_rs1_data = i_wr_data;
        else
            o_rs1_data = regs[i_rs1_sel];

        if (i_rs2_sel == '0)
            o_rs2_data = '0;
        else if (i_wr_en && (i_rs2_sel == i_rd_sel))
            o_rs2_data = i_wr_data;
        else
            o_rs2_data = regs[i_rs2_sel];
    end

endmodule

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import rv_isa_pkg::*; (
    input  wire   word_t i_a,
    input  wire   word_t i_b,
    input  wire   alu_op_e i_op,
    output word_t o_result
);

    logic [4:0] shamt;

    assign shamt = i_b[4:0];

    always_comb
    begin
        case (i_op)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SLL:  o_result = i_a << shamt;
            ALU_SRL:  o_result = i_a >> shamt;
            ALU_SRA:  o_result = word_t'($signed(i_a) >>> shamt);
            // Compares give 0 or 1
            ALU_SLT:  o_result = word_t'($signed(i_a) < $signed(i_b));
            ALU_SLTU: o_result = word_t'(i_a < i_b);
            default:  o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module data_mem import rv_isa_pkg::*; (
    input  wire   clk,
    input  wire   rst,
    input  wire   word_t i_addr,
    input  wire   i_wr_en,
    input  wire   word_t i_wr_data,
    input  wire   i_rd_en,
    output word_t o_rd_data
);

    localparam int ADDR_BITS = $clog2(`DMEM_WORDS);

    word_t                mem [`DMEM_WORDS];
    logic [ADDR_BITS-1:0] index;

    // Word index, upper address bits wrap
    assign index = i_addr[ADDR_BITS+1:2];

    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `DMEM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (i_wr_en)
        begin
            mem[index] <= i_wr_data;
        end
    end

    assign o_rd_data = i_rd_en ? mem[index] : '0;

endmodule

`default_nettype wire

/* design/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_isa_pkg::*, pipe_pkg::*; (
    input  wire      clk,
    input  wire      rst,
    output word_t    o_pc,
    input  wire      word_t i_instruction,
    output logic     o_wb_en,
    output reg_sel_t o_wb_rd,
    output word_t    o_wb_data
);

    word_t    pc;
    if_id_t   if_id_d;
    if_id_t   if_id_q;
    id_ex_t   id_ex_d;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_mem_d;
    ex_mem_t  ex_mem_q;
    mem_wb_t  mem_wb_d;
    mem_wb_t  mem_wb_q;

    reg_sel_t rs1_sel;
    reg_sel_t rs2_sel;
    word_t    operand_b;
    word_t    wb_data;

    // Fetch, no stalls so the PC always moves on
    always_ff @(posedge clk, posedge rst)
    begin
        if (rst)
        begin
            pc <= '0;
        end
        else
        begin
            pc <= pc + word_t'(4);
        end
    end

    assign o_pc = pc;
    assign if_id_d.instruction = i_instruction;

    if_id u_if_id (.clk(clk), .rst(rst), .i_d(if_id_d), .o_q(if_id_q));

    // Decode
    decoder u_decoder (
        .i_instruction (if_id_q.instruction),
        .o_rs1_sel     (rs1_sel),
        .o_rs2_sel     (rs2_sel),
        .o_rd_sel      (id_ex_d.rd_sel),
        .o_imm         (id_ex_d.imm),
        .o_ctrl        (id_ex_d.ctrl)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .i_rs1_sel  (rs1_sel),
        .i_rs2_sel  (rs2_sel),
        .i_wr_en    (mem_wb_q.ctrl.reg_wr_en),
        .i_rd_sel   (mem_wb_q.rd_sel),
        .i_wr_data  (wb_data),
        .o_rs1_data (id_ex_d.rs_data1),
        .o_rs2_data (id_ex_d.rs_data2)
    );

    id_ex u_id_ex (.clk(clk), .rst(rst), .i_d(id_ex_d), .o_q(id_ex_q));

    // Execute
    assign operand_b = id_ex_q.ctrl.alu_src ? id_ex_q.imm : id_ex_q.rs_data2;

    alu u_alu (
        .i_a      (id_ex_q.rs_data1),
        .i_b      (operand_b),
        .i_op     (id_ex_q.ctrl.alu_op),
        .o_result (ex_mem_d.alu_result)
    );

    assign ex_mem_d.rs_data2 = id_ex_q.rs_data2;
    assign ex_mem_d.rd_sel   = id_ex_q.rd_sel;
    assign ex_mem_d.ctrl     = id_ex_q.ctrl;

    ex_mem u_ex_mem (.clk(clk), .rst(rst), .i_d(ex_mem_d), .o_q(ex_mem_q));

    // Memory
    data_mem u_data_mem (
        .clk       (clk),
        .rst       (rst),
        .i_addr    (ex_mem_q.alu_result),
        .i_wr_en   (ex_mem_q.ctrl.mem_write),
        .i_wr_data (ex_mem_q.rs_data2),
        .i_rd_en   (ex_mem_q.ctrl.mem_read),
        .o_rd_data (mem_wb_d.mem_data)
    );

    assign mem_wb_d.alu_result = ex_mem_q.alu_result;
    assign mem_wb_d.rd_sel     = ex_mem_q.rd_sel;
    assign mem_wb_d.ctrl       = ex_mem_q.ctrl;

    mem_wb u_mem_wb (.clk(clk), .rst(rst), .i_d(mem_wb_d), .o_q(mem_wb_q));

    // Writeback
    assign wb_data   = mem_wb_q.ctrl.mem_to_reg ? mem_wb_q.mem_data : mem_wb_q.alu_result;
    assign o_wb_en   = mem_wb_q.ctrl.reg_wr_en;
    assign o_wb_rd   = mem_wb_q.rd_sel;
    assign o_wb_data = wb_data;

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 4;

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release on a rising edge
    initial
    begin
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* bench/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module tb_core import rv_isa_pkg::*; ();

    localparam int    PROG_WORDS = 512;
    localparam int    CLK_PERIOD = 20;
    localparam word_t NOP        = 32'h0000_0013;

    // {alt, funct3} of every register and immediate op
    localparam logic [39:0] R_OPS = {4'b0011, 4'b0010, 4'b1101, 4'b0101, 4'b0001,
                                     4'b0100, 4'b0110, 4'b0111, 4'b1000, 4'b0000};
    localparam logic [35:0] I_OPS = {4'b1101, 4'b0101, 4'b0001, 4'b0111, 4'b0110,
                                     4'b0100, 4'b0011, 4'b0010, 4'b0000};

    typedef struct packed {
        word_t    pc;
        reg_sel_t rd;
        word_t    data;
    } wb_entry_t;

    logic      clk;
    logic      rst;
    word_t     pc;
    word_t     instruction;
    logic      wb_en;
    reg_sel_t  wb_rd;
    word_t     wb_data;

    word_t     prog [PROG_WORDS];
    int        prog_len = 0;
    logic      program_ready = 1'b0;
    word_t     rng_state = 32'hd22ef31d;
    word_t     model_regs [`REG_COUNT];
    word_t     model_mem [`DMEM_WORDS];
    wb_entry_t expected [$];
    word_t     pc_hist [$];
    int        cycle = 0;

    tb_clock u_clock (.clk(clk), .rst(rst));

    // NOP past the end of the program
    assign instruction = ((pc >> 2) < prog_len) ? prog[pc >> 2] : NOP;

    rv_core i_rv_core (
        .clk           (clk),
        .rst           (rst),
        .o_pc          (pc),
        .i_instruction (instruction),
        .o_wb_en       (wb_en),
        .o_wb_rd       (wb_rd),
        .o_wb_data     (wb_data)
    );

    task automatic halt_failed();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string name, input word_t exp, input word_t act);
        $display("FAILED at %0t: %s expected %h, actual %h", $time, name, exp, act);
        halt_failed();
    endtask

    task automatic abort_run(input string what);
        $display("ERROR at %0t: %s", $time, what);
        halt_failed();
    endtask

    function automatic word_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Sources come from the seeded registers only
    function automatic reg_sel_t pick_source();
        return reg_sel_t'(1 + next_random() % 10);
    endfunction

    function automatic reg_sel_t result_reg(input int n);
        return reg_sel_t'(11 + n % 20);
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_sel_t rd, input reg_sel_t rs1, input reg_sel_t rs2);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_sel_t rs1,
                                    input logic [2:0] f3, input reg_sel_t rd, input opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_sel_t rs2,
                                    input reg_sel_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_sel_t rd);
        return {imm, rd, LUI};
    endfunction

    function automatic word_t imm_i(input word_t w);
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic word_t imm_s(input word_t w);
        return {{20{w[31]}}, w[31:25], w[11:7]};
    endfunction

    // RV32I integer semantics
    function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5:
            begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Two NOPs after each slot keep dependents three slots away
    task automatic emit(input word_t word);
        prog[prog_len]     = word;
        prog[prog_len + 1] = NOP;
        prog[prog_len + 2] = NOP;
        prog_len = prog_len + 3;
    endtask

    task automatic build_program();
        word_t       v;
        logic [3:0]  sel;
        logic [11:0] imm;
        int          n;
        n = 0;
        for (int r = 1; r <= 10; r++)
        begin
            v = next_random();
            emit(enc_u(v[31:12], reg_sel_t'(r)));
            emit(enc_i(v[11:0], reg_sel_t'(r), 3'b000, reg_sel_t'(r), OP_IMM));
        end
        for (int k = 0; k < 30; k++)
        begin
            sel = R_OPS[(k % 10) * 4 +: 4];
            emit(enc_r({1'b0, sel[3], 5'b0}, sel[2:0], result_reg(n),
                       pick_source(), pick_source()));
            n++;
        end
        for (int k = 0; k < 27; k++)
        begin
            sel = I_OPS[(k % 9) * 4 +: 4];
            v = next_random();
            // Shifts carry shamt and the SRAI bit
            if (sel[1:0] == 2'b01)
                imm = {1'b0, sel[3], 5'b0, v[4:0]};
            else
                imm = v[11:0];
            emit(enc_i(imm, pick_source(), sel[2:0], result_reg(n), OP_IMM));
            n++;
        end
        emit(enc_s(12'd16, 5'd3, 5'd0));
        emit(enc_s(12'd20, 5'd4, 5'd0));
        emit(enc_i(12'd16, 5'd0, 3'b010, 5'd20, LOAD));
        emit(enc_i(12'd20, 5'd0, 3'b010, 5'd21, LOAD));
        // Word 25 is never written
        emit(enc_i(12'd100, 5'd0, 3'b010, 5'd22, LOAD));
        emit(enc_i(12'd64, 5'd0, 3'b000, 5'd11, OP_IMM));
        emit(enc_s(12'hff8, 5'd5, 5'd11));
        emit(enc_i(12'd56, 5'd0, 3'b010, 5'd23, LOAD));
        // Results aimed at x0, then x0 as a source
        emit(enc_i(12'd5, 5'd1, 3'b000, 5'd0, OP_IMM));
        emit(enc_r(7'd0, 3'b000, 5'd0, 5'd1, 5'd2));
        emit(enc_u(20'habcde, 5'd0));
        emit(enc_i(12'd16, 5'd0, 3'b010, 5'd0, LOAD));
        emit(enc_r(7'd0, 3'b000, 5'd24, 5'd0, 5'd3));
        emit(enc_i(12'hfff, 5'd0, 3'b000, 5'd25, OP_IMM));
        // Chain through write-through
        emit(enc_r(7'd0, 3'b000, 5'd26, 5'd1, 5'd2));
        emit(enc_r(7'h20, 3'b000, 5'd27, 5'd26, 5'd3));
        emit(enc_r(7'd0, 3'b100, 5'd28, 5'd27, 5'd26));
    endtask

    task automatic run_model();
        word_t      w;
        word_t      a;
        word_t      b;
        word_t      res;
        logic [2:0] f3;
        logic       wr;
        reg_sel_t   rd;
        wb_entry_t  entry;
        for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] = '0;
        for (int i = 0; i < `DMEM_WORDS; i++)
            model_mem[i] = '0;
        for (int i = 0; i < prog_len; i++)
        begin
            w   = prog[i];
            rd  = w[11:7];
            f3  = w[14:12];
            a   = model_regs[w[19:15]];
            b   = model_regs[w[24:20]];
            wr  = 1'b1;
            res = '0;
            case (w[6:0])
                OP:     res = ref_alu(f3, w[30], a, b);
                OP_IMM: res = ref_alu(f3, w[30] && (f3 == 3'd5), a, imm_i(w));
                LUI:    res = {w[31:12], 12'b0};
                LOAD:   res = model_mem[((a + imm_i(w)) >> 2) % `DMEM_WORDS];
                STORE:
                begin
                    model_mem[((a + imm_s(w)) >> 2) % `DMEM_WORDS] = b;
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            if (wr && (rd != '0))
            begin
                model_regs[rd] = res;
                entry.pc   = word_t'(i * 4);
                entry.rd   = rd;
                entry.data = res;
                expected.push_back(entry);
            end
        end
    endtask

    task automatic check_writeback();
        wb_entry_t front;
        assert (wb_rd != '0) else abort_run("writeback raised for x0");
        assert (expected.size() > 0) else abort_run("writeback with nothing left to expect");
        front = expected.pop_front();
        assert ((cycle >= 4) && (pc_hist[cycle - 4] == front.pc))
            else abort_run("writeback did not land 4 cycles after its fetch");
        assert (wb_rd == front.rd) else flag_mismatch("o_wb_rd", front.rd, wb_rd);
        assert (wb_data == front.data) else flag_mismatch("o_wb_data", front.data, wb_data);
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            // Skip the edge made by the clock's first value
            if ($time > 0)
            begin
                assert (!wb_en) else abort_run("writeback raised during reset");
                assert (pc == '0) else flag_mismatch("o_pc", '0, pc);
            end
        end
        else
        begin
            assert (pc == word_t'(cycle * 4)) else flag_mismatch("o_pc", cycle * 4, pc);
            pc_hist.push_back(pc);
            if (wb_en)
                check_writeback();
            cycle++;
        end
    end

    initial
    begin
        build_program();
        run_model();
        program_ready = 1'b1;
        wait (cycle >= prog_len + 6);
        if (expected.size() == 0)
        begin
            $display("Everything OK");
            $finish;
        end
        else
        begin
            abort_run("expected writebacks never appeared");
        end
    end

    initial
    begin
        wait (program_ready);
        #((prog_len + 20) * CLK_PERIOD);
        abort_run("watchdog expired before the program drained");
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/rv_isa_pkg.sv
design/pipe_pkg.sv
design/pipe_regs.sv
design/decoder.sv
design/reg_file.sv
design/alu.sv
design/data_mem.sv
design/rv_core.sv
bench/tb_clock.sv
bench/tb_core.sv
